/* common/dispatch_pkg.sv */
// shared widths and stall-vector indices for the dispatch register stage and its testbench
package dispatch_pkg;

    // datapath widths
    localparam int xlen        = 32;
    localparam int inst_addr_w = 32;
    localparam int inst_w      = 32;
    localparam int commit_id_w = 4;
    localparam int reg_addr_w  = 5;

    // alu op code width
    localparam int alu_op_w = 4;

    // one-hot branch op vector
    // bit order: jal, beq, bne, blt, bltu, bge, bgeu, jalr
    localparam int bjp_op_w = 8;

    // memory op vector
    // bit order: lb, lh, lw, lbu, lhu, ldh, ldl, load, store
    localparam int mem_op_w = 9;

    // system op vector
    // bit order: nop, mret, ecall, ebreak, fence, dret
    localparam int sys_op_w       = 6;
    localparam int sys_op_nop_bit = 0;

    // byte enables for a word store
    localparam int wmask_w = 4;

    // stall vector from the control unit
    localparam int stall_w            = 3;
    // only this bit freezes the stage, the others flush it
    localparam int stall_dispatch_bit = 1;

endpackage

/* hw/inst_info_slice.sv */
// pipeline registers for instruction tracking info and system ops, flushed on stall
`timescale 1ns/1ps

module inst_info_slice (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                update_en_i,
    input  logic                                flush_en_i,

    input  logic                                inst_valid_i,
    input  logic [dispatch_pkg::inst_addr_w-1:0] inst_addr_i,
    input  logic [dispatch_pkg::commit_id_w-1:0] commit_id_i,
    input  logic [dispatch_pkg::inst_w-1:0]     inst_i,
    input  logic                                illegal_inst_i,
    input  logic                                reg_we_i,
    input  logic [dispatch_pkg::reg_addr_w-1:0] reg_waddr_i,
    input  logic [dispatch_pkg::xlen-1:0]       rs1_rdata_i,
    input  logic [dispatch_pkg::xlen-1:0]       rs2_rdata_i,
    input  logic                                is_pred_branch_i,
    input  logic [dispatch_pkg::sys_op_w-1:0]   sys_op_i,

    output logic                                inst_valid_o,
    output logic [dispatch_pkg::inst_addr_w-1:0] inst_addr_o,
    output logic [dispatch_pkg::commit_id_w-1:0] commit_id_o,
    output logic [dispatch_pkg::inst_w-1:0]     inst_o,
    output logic                                illegal_inst_o,
    output logic                                reg_we_o,
    output logic [dispatch_pkg::reg_addr_w-1:0] reg_waddr_o,
    output logic [dispatch_pkg::xlen-1:0]       rs1_rdata_o,
    output logic [dispatch_pkg::xlen-1:0]       rs2_rdata_o,
    output logic                                is_pred_branch_o,
    output logic [dispatch_pkg::sys_op_w-1:0]   sys_op_o
);

    import dispatch_pkg::*;

    logic [sys_op_w-1:0] sys_op_keep;

    // trap-causing sys ops die on flush, nop is just a tag
    always_comb begin
        sys_op_keep = {sys_op_w{~flush_en_i}};
        sys_op_keep[sys_op_nop_bit] = 1'b1;
    end

    // flushable status bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o   <= 1'b0;
            illegal_inst_o <= 1'b0;
            sys_op_o       <= '0;
        end else if (update_en_i) begin
            inst_valid_o   <= inst_valid_i & ~flush_en_i;
            illegal_inst_o <= illegal_inst_i & ~flush_en_i;
            sys_op_o       <= sys_op_i & sys_op_keep;
        end
    end

    // tracking fields load even on flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_addr_o      <= '0;
            commit_id_o      <= '0;
            inst_o           <= '0;
            reg_we_o         <= 1'b0;
            reg_waddr_o      <= '0;
            rs1_rdata_o      <= '0;
            rs2_rdata_o      <= '0;
            is_pred_branch_o <= 1'b0;
        end else if (update_en_i) begin
            inst_addr_o      <= inst_addr_i;
            commit_id_o      <= commit_id_i;
            inst_o           <= inst_i;
            reg_we_o         <= reg_we_i;
            reg_waddr_o      <= reg_waddr_i;
            rs1_rdata_o      <= rs1_rdata_i;
            rs2_rdata_o      <= rs2_rdata_i;
            is_pred_branch_o <= is_pred_branch_i;
        end
    end

endmodule

/* hw/exu_req_slice.sv */
// pipeline registers for alu and branch/jump requests with their operands
`timescale 1ns/1ps

module exu_req_slice (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                update_en_i,
    input  logic                                flush_en_i,

    input  logic                                req_alu_i,
    input  logic [dispatch_pkg::xlen-1:0]       alu_op1_i,
    input  logic [dispatch_pkg::xlen-1:0]       alu_op2_i,
    input  logic [dispatch_pkg::alu_op_w-1:0]   alu_op_info_i,
    input  logic                                req_bjp_i,
    input  logic [dispatch_pkg::bjp_op_w-1:0]   bjp_op_i,
    input  logic [dispatch_pkg::xlen-1:0]       bjp_adder_result_i,
    input  logic [dispatch_pkg::xlen-1:0]       bjp_next_pc_i,
    input  logic                                op1_eq_op2_i,
    input  logic                                op1_ge_op2_signed_i,
    input  logic                                op1_ge_op2_unsigned_i,

    output logic                                req_alu_o,
    output logic [dispatch_pkg::xlen-1:0]       alu_op1_o,
    output logic [dispatch_pkg::xlen-1:0]       alu_op2_o,
    output logic [dispatch_pkg::alu_op_w-1:0]   alu_op_info_o,
    output logic                                req_bjp_o,
    output logic [dispatch_pkg::bjp_op_w-1:0]   bjp_op_o,
    output logic [dispatch_pkg::xlen-1:0]       bjp_adder_result_o,
    output logic [dispatch_pkg::xlen-1:0]       bjp_next_pc_o,
    output logic                                op1_eq_op2_o,
    output logic                                op1_ge_op2_signed_o,
    output logic                                op1_ge_op2_unsigned_o
);

    // request bits, single-cycle pulses toward the units
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_alu_o <= 1'b0;
            req_bjp_o <= 1'b0;
        end else if (update_en_i) begin
            req_alu_o <= req_alu_i & ~flush_en_i;
            req_bjp_o <= req_bjp_i & ~flush_en_i;
        end
    end

    // operands and precomputed compare results
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_op1_o             <= '0;
            alu_op2_o             <= '0;
            alu_op_info_o         <= '0;
            bjp_op_o              <= '0;
            bjp_adder_result_o    <= '0;
            bjp_next_pc_o         <= '0;
            op1_eq_op2_o          <= 1'b0;
            op1_ge_op2_signed_o   <= 1'b0;
            op1_ge_op2_unsigned_o <= 1'b0;
        end else if (update_en_i) begin
            alu_op1_o             <= alu_op1_i;
            alu_op2_o             <= alu_op2_i;
            alu_op_info_o         <= alu_op_info_i;
            bjp_op_o              <= bjp_op_i;
            bjp_adder_result_o    <= bjp_adder_result_i;
            bjp_next_pc_o         <= bjp_next_pc_i;
            op1_eq_op2_o          <= op1_eq_op2_i;
            op1_ge_op2_signed_o   <= op1_ge_op2_signed_i;
            op1_ge_op2_unsigned_o <= op1_ge_op2_unsigned_i;
        end
    end

endmodule

/* hw/mem_req_slice.sv */
// pipeline registers for the memory request; an atomic lock shields it from flush
`timescale 1ns/1ps

module mem_req_slice (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                update_en_i,
    input  logic                                flush_en_i,
    input  logic                                agu_atom_lock_i,

    input  logic                                req_mem_i,
    input  logic [dispatch_pkg::mem_op_w-1:0]   mem_op_i,
    input  logic [dispatch_pkg::xlen-1:0]       mem_addr_i,
    input  logic [dispatch_pkg::wmask_w-1:0]    mem_wmask_i,
    input  logic [dispatch_pkg::xlen-1:0]       mem_wdata_i,
    input  logic [dispatch_pkg::commit_id_w-1:0] mem_commit_id_i,
    input  logic [dispatch_pkg::reg_addr_w-1:0] mem_reg_waddr_i,
    input  logic                                misaligned_load_i,
    input  logic                                misaligned_store_i,

    output logic                                req_mem_o,
    output logic [dispatch_pkg::mem_op_w-1:0]   mem_op_o,
    output logic [dispatch_pkg::xlen-1:0]       mem_addr_o,
    output logic [dispatch_pkg::wmask_w-1:0]    mem_wmask_o,
    output logic [dispatch_pkg::xlen-1:0]       mem_wdata_o,
    output logic [dispatch_pkg::commit_id_w-1:0] mem_commit_id_o,
    output logic [dispatch_pkg::reg_addr_w-1:0] mem_reg_waddr_o,
    output logic                                misaligned_load_o,
    output logic                                misaligned_store_o
);

    logic req_flush;

    // an atomic sequence in the agu must not lose its access
    assign req_flush = flush_en_i & ~agu_atom_lock_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_mem_o          <= 1'b0;
            misaligned_load_o  <= 1'b0;
            misaligned_store_o <= 1'b0;
        end else if (update_en_i) begin
            req_mem_o          <= req_mem_i & ~req_flush;
            // exceptions go regardless of the lock
            misaligned_load_o  <= misaligned_load_i & ~flush_en_i;
            misaligned_store_o <= misaligned_store_i & ~flush_en_i;
        end
    end

    // access payload
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_op_o        <= '0;
            mem_addr_o      <= '0;
            mem_wmask_o     <= '0;
            mem_wdata_o     <= '0;
            mem_commit_id_o <= '0;
            mem_reg_waddr_o <= '0;
        end else if (update_en_i) begin
            mem_op_o        <= mem_op_i;
            mem_addr_o      <= mem_addr_i;
            mem_wmask_o     <= mem_wmask_i;
            mem_wdata_o     <= mem_wdata_i;
            mem_commit_id_o <= mem_commit_id_i;
            mem_reg_waddr_o <= mem_reg_waddr_i;
        end
    end

endmodule

/* hw/dispatch_pipe.sv */
// dispatch-to-execute register stage top; decodes the stall vector and drives the three slices
`timescale 1ns/1ps

module dispatch_pipe (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [dispatch_pkg::stall_w-1:0]    stall_flag_i,
    input  logic                                agu_atom_lock_i,

    // instruction information
    input  logic                                inst_valid_i,
    input  logic [dispatch_pkg::inst_addr_w-1:0] inst_addr_i,
    input  logic [dispatch_pkg::commit_id_w-1:0] commit_id_i,
    input  logic [dispatch_pkg::inst_w-1:0]     inst_i,
    input  logic                                illegal_inst_i,
    input  logic                                reg_we_i,
    input  logic [dispatch_pkg::reg_addr_w-1:0] reg_waddr_i,
    input  logic [dispatch_pkg::xlen-1:0]       rs1_rdata_i,
    input  logic [dispatch_pkg::xlen-1:0]       rs2_rdata_i,
    input  logic                                is_pred_branch_i,
    input  logic [dispatch_pkg::sys_op_w-1:0]   sys_op_i,

    // alu and branch/jump
    input  logic                                req_alu_i,
    input  logic [dispatch_pkg::xlen-1:0]       alu_op1_i,
    input  logic [dispatch_pkg::xlen-1:0]       alu_op2_i,
    input  logic [dispatch_pkg::alu_op_w-1:0]   alu_op_info_i,
    input  logic                                req_bjp_i,
    input  logic [dispatch_pkg::bjp_op_w-1:0]   bjp_op_i,
    input  logic [dispatch_pkg::xlen-1:0]       bjp_adder_result_i,
    input  logic [dispatch_pkg::xlen-1:0]       bjp_next_pc_i,
    input  logic                                op1_eq_op2_i,
    input  logic                                op1_ge_op2_signed_i,
    input  logic                                op1_ge_op2_unsigned_i,

    // memory access
    input  logic                                req_mem_i,
    input  logic [dispatch_pkg::mem_op_w-1:0]   mem_op_i,
    input  logic [dispatch_pkg::xlen-1:0]       mem_addr_i,
    input  logic [dispatch_pkg::wmask_w-1:0]    mem_wmask_i,
    input  logic [dispatch_pkg::xlen-1:0]       mem_wdata_i,
    input  logic [dispatch_pkg::commit_id_w-1:0] mem_commit_id_i,
    input  logic [dispatch_pkg::reg_addr_w-1:0] mem_reg_waddr_i,
    input  logic                                misaligned_load_i,
    input  logic                                misaligned_store_i,

    output logic                                inst_valid_o,
    output logic [dispatch_pkg::inst_addr_w-1:0] inst_addr_o,
    output logic [dispatch_pkg::commit_id_w-1:0] commit_id_o,
    output logic [dispatch_pkg::inst_w-1:0]     inst_o,
    output logic                                illegal_inst_o,
    output logic                                reg_we_o,
    output logic [dispatch_pkg::reg_addr_w-1:0] reg_waddr_o,
    output logic [dispatch_pkg::xlen-1:0]       rs1_rdata_o,
    output logic [dispatch_pkg::xlen-1:0]       rs2_rdata_o,
    output logic                                is_pred_branch_o,
    output logic [dispatch_pkg::sys_op_w-1:0]   sys_op_o,

    output logic                                req_alu_o,
    output logic [dispatch_pkg::xlen-1:0]       alu_op1_o,
    output logic [dispatch_pkg::xlen-1:0]       alu_op2_o,
    output logic [dispatch_pkg::alu_op_w-1:0]   alu_op_info_o,
    output logic                                req_bjp_o,
    output logic [dispatch_pkg::bjp_op_w-1:0]   bjp_op_o,
    output logic [dispatch_pkg::xlen-1:0]       bjp_adder_result_o,
    output logic [dispatch_pkg::xlen-1:0]       bjp_next_pc_o,
    output logic                                op1_eq_op2_o,
    output logic                                op1_ge_op2_signed_o,
    output logic                                op1_ge_op2_unsigned_o,

    output logic                                req_mem_o,
    output logic [dispatch_pkg::mem_op_w-1:0]   mem_op_o,
    output logic [dispatch_pkg::xlen-1:0]       mem_addr_o,
    output logic [dispatch_pkg::wmask_w-1:0]    mem_wmask_o,
    output logic [dispatch_pkg::xlen-1:0]       mem_wdata_o,
    output logic [dispatch_pkg::commit_id_w-1:0] mem_commit_id_o,
    output logic [dispatch_pkg::reg_addr_w-1:0] mem_reg_waddr_o,
    output logic                                misaligned_load_o,
    output logic                                misaligned_store_o
);

    import dispatch_pkg::*;

    logic update_en;
    logic flush_en;

    // dispatch stall freezes everything, any stall bit kills the entry
    assign update_en = ~stall_flag_i[stall_dispatch_bit];
    assign flush_en  = |stall_flag_i;

    inst_info_slice u_inst_info (
        .update_en_i (update_en),
        .flush_en_i  (flush_en),
        .*
    );

    exu_req_slice u_exu_req (
        .update_en_i (update_en),
        .flush_en_i  (flush_en),
        .*
    );

    // lock exemption is applied inside the memory slice
    mem_req_slice u_mem_req (
        .update_en_i (update_en),
        .flush_en_i  (flush_en),
        .*
    );

endmodule

/* sim/tb_dispatch_pipe.sv */
// self-checking testbench for the dispatch register stage, built and run from the Makefile
`timescale 1ns/1ps

module tb_dispatch_pipe;

    import dispatch_pkg::*;

    localparam int vec_w       = 381;
    localparam int n_fields    = 31;
    localparam int clk_period  = 20;
    localparam int n_reset     = 5;
    localparam int n_pass      = 20;
    localparam int n_stall     = 8;
    localparam int n_flush     = 20;
    localparam int n_lock      = 20;
    localparam int n_random    = 400;
    // two settle cycles per test
    localparam int total_cycles = n_reset + n_pass + n_stall + n_flush + n_lock + n_random
                                  + 12;
    localparam int watchdog_ns = (total_cycles + 50) * clk_period;
    localparam int mode_pass   = 0;
    localparam int mode_stall  = 1;
    localparam int mode_flush  = 2;
    localparam int mode_lock   = 3;
    localparam int mode_random = 4;

    logic clk;
    logic rst_n_i;
    logic [stall_w-1:0] stall_flag_i;
    logic agu_atom_lock_i;

    logic inst_valid_i, illegal_inst_i, reg_we_i, is_pred_branch_i, req_alu_i, req_bjp_i;
    logic op1_eq_op2_i, op1_ge_op2_signed_i, op1_ge_op2_unsigned_i, req_mem_i;
    logic misaligned_load_i, misaligned_store_i;
    logic [xlen-1:0] rs1_rdata_i, rs2_rdata_i, alu_op1_i, alu_op2_i, bjp_adder_result_i;
    logic [xlen-1:0] bjp_next_pc_i, mem_addr_i, mem_wdata_i;
    logic [inst_addr_w-1:0] inst_addr_i;
    logic [inst_w-1:0] inst_i;
    logic [commit_id_w-1:0] commit_id_i, mem_commit_id_i;
    logic [reg_addr_w-1:0] reg_waddr_i, mem_reg_waddr_i;
    logic [sys_op_w-1:0] sys_op_i;
    logic [alu_op_w-1:0] alu_op_info_i;
    logic [bjp_op_w-1:0] bjp_op_i;
    logic [mem_op_w-1:0] mem_op_i;
    logic [wmask_w-1:0] mem_wmask_i;

    logic inst_valid_o, illegal_inst_o, reg_we_o, is_pred_branch_o, req_alu_o, req_bjp_o;
    logic op1_eq_op2_o, op1_ge_op2_signed_o, op1_ge_op2_unsigned_o, req_mem_o;
    logic misaligned_load_o, misaligned_store_o;
    logic [xlen-1:0] rs1_rdata_o, rs2_rdata_o, alu_op1_o, alu_op2_o, bjp_adder_result_o;
    logic [xlen-1:0] bjp_next_pc_o, mem_addr_o, mem_wdata_o;
    logic [inst_addr_w-1:0] inst_addr_o;
    logic [inst_w-1:0] inst_o;
    logic [commit_id_w-1:0] commit_id_o, mem_commit_id_o;
    logic [reg_addr_w-1:0] reg_waddr_o, mem_reg_waddr_o;
    logic [sys_op_w-1:0] sys_op_o;
    logic [alu_op_w-1:0] alu_op_info_o;
    logic [bjp_op_w-1:0] bjp_op_o;
    logic [mem_op_w-1:0] mem_op_o;
    logic [wmask_w-1:0] mem_wmask_o;

    logic [vec_w-1:0] in_vec;
    logic [vec_w-1:0] out_vec;
    logic [vec_w-1:0] exp_vec;
    logic [vec_w-1:0] flush_bits;
    logic [vec_w-1:0] mem_req_bit;
    logic checking;
    int err_count;
    int check_count;
    int tests_run;
    int tests_failed;

    // field order below matches both concatenations with the first field at the top
    assign {inst_valid_i, inst_addr_i, commit_id_i, inst_i, illegal_inst_i, reg_we_i,
            reg_waddr_i, rs1_rdata_i, rs2_rdata_i, is_pred_branch_i, sys_op_i,
            req_alu_i, alu_op1_i, alu_op2_i, alu_op_info_i, req_bjp_i, bjp_op_i,
            bjp_adder_result_i, bjp_next_pc_i, op1_eq_op2_i, op1_ge_op2_signed_i,
            op1_ge_op2_unsigned_i, req_mem_i, mem_op_i, mem_addr_i, mem_wmask_i,
            mem_wdata_i, mem_commit_id_i, mem_reg_waddr_i, misaligned_load_i,
            misaligned_store_i} = in_vec;

    assign out_vec = {inst_valid_o, inst_addr_o, commit_id_o, inst_o, illegal_inst_o,
            reg_we_o, reg_waddr_o, rs1_rdata_o, rs2_rdata_o, is_pred_branch_o, sys_op_o,
            req_alu_o, alu_op1_o, alu_op2_o, alu_op_info_o, req_bjp_o, bjp_op_o,
            bjp_adder_result_o, bjp_next_pc_o, op1_eq_op2_o, op1_ge_op2_signed_o,
            op1_ge_op2_unsigned_o, req_mem_o, mem_op_o, mem_addr_o, mem_wmask_o,
            mem_wdata_o, mem_commit_id_o, mem_reg_waddr_o, misaligned_load_o,
            misaligned_store_o};

    string names [n_fields] = '{
        "inst_valid", "inst_addr", "commit_id", "inst", "illegal_inst", "reg_we",
        "reg_waddr", "rs1_rdata", "rs2_rdata", "is_pred_branch", "sys_op",
        "req_alu", "alu_op1", "alu_op2", "alu_op_info", "req_bjp", "bjp_op",
        "bjp_adder_result", "bjp_next_pc", "op1_eq_op2", "op1_ge_op2_signed",
        "op1_ge_op2_unsigned", "req_mem", "mem_op", "mem_addr", "mem_wmask",
        "mem_wdata", "mem_commit_id", "mem_reg_waddr", "misaligned_load", "misaligned_store"
    };
    int widths [n_fields] = '{
        1, inst_addr_w, commit_id_w, inst_w, 1, 1, reg_addr_w, xlen, xlen, 1, sys_op_w,
        1, xlen, xlen, alu_op_w, 1, bjp_op_w, xlen, xlen, 1, 1, 1,
        1, mem_op_w, xlen, wmask_w, xlen, commit_id_w, reg_addr_w, 1, 1
    };
    // 0 data, 1 cleared on flush, 2 system ops, 3 memory request
    int kinds [n_fields] = '{
        1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 2,
        1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0,
        3, 0, 0, 0, 0, 0, 0, 1, 1
    };

    dispatch_pipe dut_i (.*);

    function automatic int field_lsb(input int idx);
        int lsb;
        lsb = 0;
        for (int j = idx + 1; j < n_fields; j++) begin
            lsb += widths[j];
        end
        return lsb;
    endfunction

    function automatic logic [vec_w-1:0] field_mask(input int idx);
        logic [vec_w-1:0] one;
        one = {{(vec_w - 1){1'b0}}, 1'b1};
        return ((one << widths[idx]) - one) << field_lsb(idx);
    endfunction

    function automatic logic [31:0] field_value(input logic [vec_w-1:0] vec, input int idx);
        logic [vec_w-1:0] sel;
        sel = (vec & field_mask(idx)) >> field_lsb(idx);
        return sel[31:0];
    endfunction

    // next expected outputs from the stall, flush and lock rules
    function automatic logic [vec_w-1:0] ref_next(input logic [vec_w-1:0] prev,
                                                   input logic [vec_w-1:0] fields,
                                                   input logic [stall_w-1:0] stall,
                                                   input logic lock);
        logic [vec_w-1:0] nxt;
        if (stall[stall_dispatch_bit]) begin
            return prev;
        end
        nxt = fields;
        if (|stall) begin
            nxt = nxt & ~flush_bits;
            if (!lock) begin
                nxt = nxt & ~mem_req_bit;
            end
        end
        return nxt;
    endfunction

    function automatic logic [vec_w-1:0] rand_vec();
        logic [383:0] r;
        r = '0;
        for (int i = 0; i < 12; i++) begin
            r = {r[351:0], $urandom};
        end
        return r[vec_w-1:0];
    endfunction

    task automatic compare_outputs();
        logic [31:0] act;
        logic [31:0] expv;
        for (int i = 0; i < n_fields; i++) begin
            act = field_value(out_vec, i);
            expv = field_value(exp_vec, i);
            check_count++;
            assert (act == expv) else begin
                $display("[ERROR] t=%0t %s_o expected %0h actual %0h",
                         $time, names[i], expv, act);
                err_count++;
            end
        end
    endtask

    task automatic drive_cycles(input int mode, input int n);
        logic [stall_w-1:0] s;
        for (int c = 0; c < n; c++) begin
            @(posedge clk);
            #2;
            in_vec = rand_vec();
            s = stall_w'($urandom);
            case (mode)
                mode_pass: s = '0;
                mode_stall: s[stall_dispatch_bit] = 1'b1;
                mode_flush, mode_lock: begin
                    s[stall_dispatch_bit] = 1'b0;
                    if (s == '0) begin
                        s[(stall_dispatch_bit + 1) % stall_w] = 1'b1;
                    end
                    // every clearable bit high so a missed clear shows
                    in_vec = in_vec | flush_bits | mem_req_bit;
                end
                default: ;
            endcase
            stall_flag_i = s;
            if (mode == mode_flush) begin
                agu_atom_lock_i = 1'b0;
            end else if (mode == mode_lock) begin
                agu_atom_lock_i = 1'b1;
            end else begin
                agu_atom_lock_i = 1'($urandom);
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        int errs;
        errs = err_count - err_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errs);
        end
    endtask

    task automatic run_test(input string name, input int mode, input int n);
        int err_before;
        err_before = err_count;
        drive_cycles(mode, n);
        // last item shows up one edge later
        @(posedge clk);
        @(negedge clk);
        #1;
        report_test(name, err_before);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // reference model
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_vec <= '0;
        end else begin
            exp_vec <= ref_next(exp_vec, in_vec, stall_flag_i, agu_atom_lock_i);
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            compare_outputs();
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int err_before;
        logic [vec_w-1:0] nop_bit;
        void'($urandom(32'h4791));
        err_count = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        checking = 1'b0;
        rst_n_i = 1'b0;
        stall_flag_i = '0;
        agu_atom_lock_i = 1'b0;
        in_vec = '0;
        flush_bits = '0;
        mem_req_bit = '0;
        for (int i = 0; i < n_fields; i++) begin
            nop_bit = {{(vec_w - 1){1'b0}}, 1'b1} << (field_lsb(i) + sys_op_nop_bit);
            case (kinds[i])
                1: flush_bits = flush_bits | field_mask(i);
                2: flush_bits = flush_bits | (field_mask(i) & ~nop_bit);
                3: mem_req_bit = field_mask(i);
                default: ;
            endcase
        end

        // reset held for n_reset edges while inputs toggle
        err_before = err_count;
        @(posedge clk);
        #2;
        checking = 1'b1;
        drive_cycles(mode_random, n_reset - 1);
        rst_n_i = 1'b1;
        @(negedge clk);
        #1;
        report_test("reset", err_before);

        run_test("pass_through", mode_pass, n_pass);
        run_test("dispatch_stall", mode_stall, n_stall);
        run_test("flush", mode_flush, n_flush);
        run_test("atomic_lock", mode_lock, n_lock);
        run_test("random_mix", mode_random, n_random);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
common/dispatch_pkg.sv
hw/inst_info_slice.sv
hw/exu_req_slice.sv
hw/mem_req_slice.sv
hw/dispatch_pipe.sv
sim/tb_dispatch_pipe.sv

/* Makefile */
# Verilator build and run for the dispatch register stage

VERILATOR ?= verilator
TOP       ?= tb_dispatch_pipe
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
